// File: include/host_domain_config.svh
////////////////////////////////////////////////////////////////////////////
// Host domain configuration
// Bus widths, credit count, L2 geometry and the region address map
////////////////////////////////////////////////////////////////////////////

`ifndef HOST_DOMAIN_CONFIG_SVH
`define HOST_DOMAIN_CONFIG_SVH

// Bus widths
`define HD_DATA_W 32
`define HD_ADDR_W 32

// Request queue depth and the host's credit count after reset
`define HD_CREDITS 4

// L2 geometry
`define HD_L2_BANKS      4
`define HD_L2_BANK_WORDS 64

// Region nibbles in address bits [31:28]
`define HD_L2_BASE     4'h0
`define HD_PERIPH_BASE 4'h1

`define HD_NUM_GPIO 16

`endif

// File: logic/host_domain_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Host domain types
// Request and response words, target request and the address union
////////////////////////////////////////////////////////////////////////////

`include "host_domain_config.svh"

package host_domain_pkg;

  localparam int unsigned BANK_W = $clog2(`HD_L2_BANKS);
  // Index is wider than a bank so stray addresses in the region stay visible
  localparam int unsigned L2_IDX_W = $clog2(`HD_L2_BANK_WORDS) + 2;
  localparam int unsigned L2_PAD_W = `HD_ADDR_W - 4 - L2_IDX_W - BANK_W - 2;
  localparam int unsigned PERIPH_PAD_W = `HD_ADDR_W - 4 - 2 - 2;
  localparam int unsigned STRB_W = `HD_DATA_W / 8;

  typedef enum logic [1:0] {
    GPIO_OUT = 2'd0,
    GPIO_DIR = 2'd1,
    GPIO_IN  = 2'd2,
    SCRATCH  = 2'd3
  } periph_reg_e;

  // Consecutive words land in consecutive banks
  typedef struct packed {
    logic [3:0]          region;
    logic [L2_PAD_W-1:0] unused;
    logic [L2_IDX_W-1:0] idx;
    logic [BANK_W-1:0]   bank;
    logic [1:0]          offset;
  } l2_addr_t;

  typedef struct packed {
    logic [3:0]              region;
    logic [PERIPH_PAD_W-1:0] unused;
    periph_reg_e             idx;
    logic [1:0]              offset;
  } periph_addr_t;

  typedef union packed {
    l2_addr_t     l2;
    periph_addr_t periph;
  } host_addr_u;

  typedef struct packed {
    logic                  write;
    host_addr_u            addr;
    logic [`HD_DATA_W-1:0] wdata;
    logic [STRB_W-1:0]     strb;
  } host_req_t;

  typedef struct packed {
    logic [`HD_DATA_W-1:0] rdata;
    logic                  err;
  } host_rsp_t;

  typedef struct packed {
    logic                  write;
    host_addr_u            addr;
    logic [`HD_DATA_W-1:0] wdata;
    logic [STRB_W-1:0]     strb;
  } tgt_req_t;

endpackage

// File: logic/host_xbar.sv
////////////////////////////////////////////////////////////////////////////
// Host crossbar
// Credit managed request queue, region decode to L2 or peripherals,
// and in-order response return one cycle after the target access
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "host_domain_config.svh"

module host_xbar (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       req_valid_i,
  input  host_domain_pkg::host_req_t req_i,
  output logic                       credit_o,
  output logic                       rsp_valid_o,
  output host_domain_pkg::host_rsp_t rsp_o,
  output host_domain_pkg::tgt_req_t  tgt_req_o,
  output logic                       l2_sel_o,
  output logic                       periph_sel_o,
  input  logic [`HD_DATA_W-1:0]      l2_rdata_i,
  input  logic [`HD_DATA_W-1:0]      periph_rdata_i
);
  import host_domain_pkg::*;

  localparam int unsigned DEPTH = `HD_CREDITS;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  host_req_t        fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;
  logic             fifo_full;
  host_req_t        head;
  logic             hit_l2;
  logic             hit_periph;
  logic             rsp_valid_q;
  logic             rsp_l2_q;
  logic             rsp_periph_q;
  logic             rsp_err_q;
  logic             credit_q;

  // The host only pushes while holding a credit, so no ready is needed
  assign push      = req_valid_i;
  assign pop       = (count_q != '0);
  assign fifo_full = (count_q == CNT_W'(DEPTH));
  assign head      = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Region decode on the queue head
  assign hit_l2     = (head.addr.l2.region == `HD_L2_BASE);
  assign hit_periph = (head.addr.l2.region == `HD_PERIPH_BASE);

  assign tgt_req_o = '{write: head.write, addr: head.addr, wdata: head.wdata,
                       strb: head.strb};
  assign l2_sel_o     = pop && hit_l2;
  assign periph_sel_o = pop && hit_periph;

  // Tracks who answers the access made at the pop edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q  <= 1'b0;
      rsp_l2_q     <= 1'b0;
      rsp_periph_q <= 1'b0;
      rsp_err_q    <= 1'b0;
      credit_q     <= 1'b0;
    end else begin
      rsp_valid_q  <= pop;
      rsp_l2_q     <= pop && hit_l2 && !head.write;
      rsp_periph_q <= pop && hit_periph && !head.write;
      rsp_err_q    <= pop && !hit_l2 && !hit_periph;
      credit_q     <= pop;
    end
  end

  assign credit_o    = credit_q;
  assign rsp_valid_o = rsp_valid_q;

  // Writes and unmapped accesses return zero data
  always_comb begin
    rsp_o.err = rsp_err_q;
    if (rsp_l2_q) begin
      rsp_o.rdata = l2_rdata_i;
    end else if (rsp_periph_q) begin
      rsp_o.rdata = periph_rdata_i;
    end else begin
      rsp_o.rdata = '0;
    end
  end

  // A push into a full queue means the host spent a credit it did not hold
  assert property (@(posedge clk_i) disable iff (!arst_n_i) !(push && fifo_full))
    else $error("Host credit violation, request pushed into a full queue");

endmodule

// File: logic/l2_banks.sv
////////////////////////////////////////////////////////////////////////////
// L2 scratch memory
// Word interleaved banks with byte strobes and a registered read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "host_domain_config.svh"

module l2_banks (
  input  logic                      clk_i,
  input  host_domain_pkg::tgt_req_t tgt_req_i,
  input  logic                      sel_i,
  output logic [`HD_DATA_W-1:0]     rdata_o
);
  import host_domain_pkg::*;

  localparam int unsigned ROW_W = $clog2(`HD_L2_BANK_WORDS);

  logic [`HD_DATA_W-1:0] bank_rdata [`HD_L2_BANKS];
  logic [BANK_W-1:0]     bank_q;
  logic [ROW_W-1:0]      row;

  assign row = tgt_req_i.addr.l2.idx[ROW_W-1:0];

  for (genvar b = 0; b < `HD_L2_BANKS; b++) begin : g_bank
    logic [`HD_DATA_W-1:0] mem [`HD_L2_BANK_WORDS];
    logic [`HD_DATA_W-1:0] rdata_q;
    logic                  bank_en;

    assign bank_en = sel_i && (tgt_req_i.addr.l2.bank == BANK_W'(b));

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (tgt_req_i.write) begin
          // Only the strobed bytes change
          for (int i = 0; i < STRB_W; i++) begin
            if (tgt_req_i.strb[i]) begin
              mem[row][8*i +: 8] <= tgt_req_i.wdata[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Remember the bank so the next cycle picks its read register
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      bank_q <= tgt_req_i.addr.l2.bank;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

  // Crossbar must not route addresses past the end of a bank
  assert property (@(posedge clk_i) sel_i |-> (tgt_req_i.addr.l2.idx < `HD_L2_BANK_WORDS))
    else $error("L2 word index beyond bank depth");

endmodule

// File: logic/periph_regs.sv
////////////////////////////////////////////////////////////////////////////
// Peripheral registers
// GPIO output, direction and input registers plus a scratch word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "host_domain_config.svh"

module periph_regs (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  host_domain_pkg::tgt_req_t tgt_req_i,
  input  logic                      sel_i,
  output logic [`HD_DATA_W-1:0]     rdata_o,
  input  logic [`HD_NUM_GPIO-1:0]   gpio_in_i,
  output logic [`HD_NUM_GPIO-1:0]   gpio_out_o,
  output logic [`HD_NUM_GPIO-1:0]   gpio_dir_o
);
  import host_domain_pkg::*;

  logic [`HD_NUM_GPIO-1:0] gpio_out_q;
  logic [`HD_NUM_GPIO-1:0] gpio_dir_q;
  logic [`HD_NUM_GPIO-1:0] gpio_in_q;
  logic [`HD_DATA_W-1:0]   scratch_q;
  logic [`HD_DATA_W-1:0]   read_word;
  periph_reg_e             reg_idx;
  logic                    wr_en;
  logic                    rd_en;

  assign reg_idx = tgt_req_i.addr.periph.idx;
  assign wr_en   = sel_i && tgt_req_i.write;
  assign rd_en   = sel_i && !tgt_req_i.write;

  // Whole word writes that leave the read only GPIO_IN alone
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      scratch_q  <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        GPIO_OUT: gpio_out_q <= tgt_req_i.wdata[`HD_NUM_GPIO-1:0];
        GPIO_DIR: gpio_dir_q <= tgt_req_i.wdata[`HD_NUM_GPIO-1:0];
        SCRATCH:  scratch_q  <= tgt_req_i.wdata;
        default:  ;
      endcase
    end
  end

  always_comb begin
    read_word = '0;
    case (reg_idx)
      GPIO_OUT: read_word[`HD_NUM_GPIO-1:0] = gpio_out_q;
      GPIO_DIR: read_word[`HD_NUM_GPIO-1:0] = gpio_dir_q;
      GPIO_IN:  read_word[`HD_NUM_GPIO-1:0] = gpio_in_q;
      SCRATCH:  read_word = scratch_q;
      default:  read_word = '0;
    endcase
  end

  // Pin sampling and registered read data
  always_ff @(posedge clk_i) begin
    gpio_in_q <= gpio_in_i;
    if (rd_en) begin
      rdata_o <= read_word;
    end
  end

  assign gpio_out_o = gpio_out_q;
  assign gpio_dir_o = gpio_dir_q;

  assert property (@(posedge clk_i) !arst_n_i |-> !sel_i)
    else $error("Peripheral access while in reset");

endmodule

// File: logic/host_domain.sv
////////////////////////////////////////////////////////////////////////////
// Host domain top
// Crossbar with banked L2 and the GPIO register block behind it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "host_domain_config.svh"

module host_domain (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       req_valid_i,
  input  host_domain_pkg::host_req_t req_i,
  output logic                       credit_o,
  output logic                       rsp_valid_o,
  output host_domain_pkg::host_rsp_t rsp_o,
  input  logic [`HD_NUM_GPIO-1:0]    gpio_in_i,
  output logic [`HD_NUM_GPIO-1:0]    gpio_out_o,
  output logic [`HD_NUM_GPIO-1:0]    gpio_dir_o
);
  import host_domain_pkg::*;

  tgt_req_t              tgt_req;
  logic                  l2_sel;
  logic                  periph_sel;
  logic [`HD_DATA_W-1:0] l2_rdata;
  logic [`HD_DATA_W-1:0] periph_rdata;

  host_xbar i_xbar (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .req_valid_i    ( req_valid_i  ),
    .req_i          ( req_i        ),
    .credit_o       ( credit_o     ),
    .rsp_valid_o    ( rsp_valid_o  ),
    .rsp_o          ( rsp_o        ),
    .tgt_req_o      ( tgt_req      ),
    .l2_sel_o       ( l2_sel       ),
    .periph_sel_o   ( periph_sel   ),
    .l2_rdata_i     ( l2_rdata     ),
    .periph_rdata_i ( periph_rdata )
  );

  l2_banks i_l2 (
    .clk_i     ( clk_i    ),
    .tgt_req_i ( tgt_req  ),
    .sel_i     ( l2_sel   ),
    .rdata_o   ( l2_rdata )
  );

  periph_regs i_periph (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .tgt_req_i  ( tgt_req      ),
    .sel_i      ( periph_sel   ),
    .rdata_o    ( periph_rdata ),
    .gpio_in_i  ( gpio_in_i    ),
    .gpio_out_o ( gpio_out_o   ),
    .gpio_dir_o ( gpio_dir_o   )
  );

endmodule

// File: testbench/tb_host_domain.sv
////////////////////////////////////////////////////////////////////////////
// Host domain testbench
// Credit-based host model with L2, GPIO and response scoreboard
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "host_domain_config.svh"

module tb_host_domain;
  import host_domain_pkg::*;

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned DW           = `HD_DATA_W;
  localparam int unsigned L2_WORDS     = `HD_L2_BANKS * `HD_L2_BANK_WORDS;
  localparam int unsigned TEST_WORDS   = 16;
  // Three L2 passes, nine peripheral, four unmapped and two bursts
  localparam int unsigned NUM_REQ      = 3 * TEST_WORDS + 9 + 4 + 2 * `HD_CREDITS;

  // Expected response and the GPIO state right after that request
  typedef struct packed {
    host_rsp_t               rsp;
    logic [`HD_NUM_GPIO-1:0] gpio_out;
    logic [`HD_NUM_GPIO-1:0] gpio_dir;
  } expect_t;

  logic                    clk;
  logic                    arst_n;
  logic                    req_valid;
  host_req_t               req;
  logic                    credit;
  logic                    rsp_valid;
  host_rsp_t               rsp;
  logic [`HD_NUM_GPIO-1:0] gpio_in;
  logic [`HD_NUM_GPIO-1:0] gpio_out;
  logic [`HD_NUM_GPIO-1:0] gpio_dir;

  integer                  seed = 32'he788_1540;
  logic [DW-1:0]           l2_model [L2_WORDS];
  logic [`HD_NUM_GPIO-1:0] gpio_out_model;
  logic [`HD_NUM_GPIO-1:0] gpio_dir_model;
  logic [DW-1:0]           scratch_model;
  int unsigned             test_words [TEST_WORDS];
  expect_t                 exp_q [$];
  expect_t                 exp_head = '0;
  logic                    exp_avail = 1'b0;
  int                      issued_cnt = 0;
  int                      returned_cnt = 0;
  int                      credit_cnt;

  host_domain dut0 (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .req_valid_i ( req_valid ),
    .req_i       ( req       ),
    .credit_o    ( credit    ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_o       ( rsp       ),
    .gpio_in_i   ( gpio_in   ),
    .gpio_out_o  ( gpio_out  ),
    .gpio_dir_o  ( gpio_dir  )
  );

  assign credit_cnt = `HD_CREDITS - issued_cnt + returned_cnt;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((NUM_REQ * 10 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout, the DUT stopped answering requests");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  function automatic logic [DW-1:0] next_random();
    return $random(seed);
  endfunction

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                                input logic [DW-1:0] new_word,
                                                input logic [STRB_W-1:0] strb);
    logic [DW-1:0] merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Word interleaving puts word w at byte address 4*w
  function automatic logic [`HD_ADDR_W-1:0] l2_addr(input int unsigned word);
    return {`HD_L2_BASE, 28'(word * 4)};
  endfunction

  function automatic logic [`HD_ADDR_W-1:0] periph_addr(input periph_reg_e idx);
    return {`HD_PERIPH_BASE, 24'h0, idx, 2'b00};
  endfunction

  // Waits at falling edges for a credit and then spends it
  task automatic send(input logic wr, input logic [`HD_ADDR_W-1:0] addr,
                      input logic [DW-1:0] wdata, input logic [STRB_W-1:0] strb,
                      input logic [DW-1:0] rdata_exp, input logic err_exp);
    expect_t exp;
    while (credit_cnt == 0) begin
      @(negedge clk);
    end
    exp.rsp.rdata = rdata_exp;
    exp.rsp.err   = err_exp;
    exp.gpio_out  = gpio_out_model;
    exp.gpio_dir  = gpio_dir_model;
    exp_q.push_back(exp);
    req.write = wr;
    req.addr  = host_addr_u'(addr);
    req.wdata = wdata;
    req.strb  = strb;
    req_valid = 1'b1;
    issued_cnt++;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || credit_cnt != `HD_CREDITS) begin
      @(negedge clk);
    end
  endtask

  // Reads values from before the update edge so each response retires once
  always @(posedge clk) begin
    if (arst_n) begin
      if (credit) begin
        returned_cnt++;
      end
      if (rsp_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      exp_head = exp_q[0];
    end
  end

  assert property (@(negedge clk) disable iff (!arst_n)
      (issued_cnt == 0) |-> (!credit && !rsp_valid))
    else report_failure("Credit or response seen before any request was sent");

  assert property (@(negedge clk) disable iff (!arst_n)
      (issued_cnt == 0) |-> (gpio_out == '0 && gpio_dir == '0))
    else report_failure($sformatf("MISMATCH gpio_out_o/gpio_dir_o: got %h/%h expected 0/0",
                                  gpio_out, gpio_dir));

  assert property (@(negedge clk) disable iff (!arst_n)
      credit_cnt >= 0 && credit_cnt <= `HD_CREDITS)
    else report_failure($sformatf("Host credit count left its range at %0d", credit_cnt));

  assert property (@(negedge clk) disable iff (!arst_n) rsp_valid |-> exp_avail)
    else report_failure("Response arrived with no request outstanding");

  assert property (@(negedge clk) disable iff (!arst_n)
      (rsp_valid && exp_avail) |-> (rsp.rdata == exp_head.rsp.rdata))
    else report_failure($sformatf("MISMATCH rsp_o.rdata: got %h expected %h",
                                  rsp.rdata, exp_head.rsp.rdata));

  assert property (@(negedge clk) disable iff (!arst_n)
      (rsp_valid && exp_avail) |-> (rsp.err == exp_head.rsp.err))
    else report_failure($sformatf("MISMATCH rsp_o.err: got %h expected %h",
                                  rsp.err, exp_head.rsp.err));

  assert property (@(negedge clk) disable iff (!arst_n)
      (rsp_valid && exp_avail) |-> (gpio_out == exp_head.gpio_out))
    else report_failure($sformatf("MISMATCH gpio_out_o: got %h expected %h",
                                  gpio_out, exp_head.gpio_out));

  assert property (@(negedge clk) disable iff (!arst_n)
      (rsp_valid && exp_avail) |-> (gpio_dir == exp_head.gpio_dir))
    else report_failure($sformatf("MISMATCH gpio_dir_o: got %h expected %h",
                                  gpio_dir, exp_head.gpio_dir));

  initial begin
    logic [DW-1:0]     data;
    logic [STRB_W-1:0] strb;
    int unsigned       w;
    arst_n         = 1'b0;
    req_valid      = 1'b0;
    req            = '0;
    gpio_in        = '0;
    gpio_out_model = '0;
    gpio_dir_model = '0;
    scratch_model  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    // Quiet window after reset
    repeat (5) @(negedge clk);

    // Full L2 words first since unwritten bytes are undefined
    for (int i = 0; i < TEST_WORDS; i++) begin
      w = ((next_random() & 63) << 2) | (i & 3);
      test_words[i] = w;
      data = next_random();
      l2_model[w] = data;
      send(1'b1, l2_addr(w), data, '1, '0, 1'b0);
    end
    for (int i = 0; i < TEST_WORDS; i++) begin
      w = test_words[i];
      data = next_random();
      strb = STRB_W'(next_random());
      l2_model[w] = merge_bytes(l2_model[w], data, strb);
      send(1'b1, l2_addr(w), data, strb, '0, 1'b0);
    end
    for (int i = 0; i < TEST_WORDS; i++) begin
      w = test_words[i];
      send(1'b0, l2_addr(w), '0, '0, l2_model[w], 1'b0);
    end
    wait_idle();

    // Peripheral registers ignore the strobe on writes
    data = next_random();
    gpio_out_model = data[`HD_NUM_GPIO-1:0];
    send(1'b1, periph_addr(GPIO_OUT), data, '1, '0, 1'b0);
    data = next_random();
    gpio_dir_model = data[`HD_NUM_GPIO-1:0];
    send(1'b1, periph_addr(GPIO_DIR), data, '1, '0, 1'b0);
    data = next_random();
    scratch_model = data;
    send(1'b1, periph_addr(SCRATCH), data, 4'h1, '0, 1'b0);
    data = next_random();
    gpio_in = data[`HD_NUM_GPIO-1:0];
    repeat (2) @(negedge clk);
    send(1'b0, periph_addr(GPIO_IN), '0, '0, DW'(gpio_in), 1'b0);
    send(1'b1, periph_addr(GPIO_IN), next_random(), '1, '0, 1'b0);
    send(1'b0, periph_addr(GPIO_IN), '0, '0, DW'(gpio_in), 1'b0);
    send(1'b0, periph_addr(SCRATCH), '0, '0, scratch_model, 1'b0);
    send(1'b0, periph_addr(GPIO_OUT), '0, '0, DW'(gpio_out_model), 1'b0);
    send(1'b0, periph_addr(GPIO_DIR), '0, '0, DW'(gpio_dir_model), 1'b0);

    // Unmapped regions
    send(1'b0, {4'h2, 28'h0000040}, '0, '0, '0, 1'b1);
    send(1'b1, {4'h2, 28'h0000040}, next_random(), '1, '0, 1'b1);
    send(1'b0, {4'hF, 28'h0000004}, '0, '0, '0, 1'b1);
    send(1'b1, {4'hF, 28'h0000004}, next_random(), '1, '0, 1'b1);
    wait_idle();

    // Two mixed bursts and the first spends every credit back to back
    data = next_random();
    l2_model[test_words[0]] = data;
    send(1'b1, l2_addr(test_words[0]), data, '1, '0, 1'b0);
    send(1'b0, periph_addr(SCRATCH), '0, '0, scratch_model, 1'b0);
    send(1'b0, {4'h3, 28'h0000100}, '0, '0, '0, 1'b1);
    send(1'b0, l2_addr(test_words[0]), '0, '0, l2_model[test_words[0]], 1'b0);
    data = next_random();
    scratch_model = data;
    send(1'b1, periph_addr(SCRATCH), data, '1, '0, 1'b0);
    send(1'b0, l2_addr(test_words[1]), '0, '0, l2_model[test_words[1]], 1'b0);
    send(1'b1, {4'h7, 28'h0000008}, next_random(), '1, '0, 1'b1);
    send(1'b0, periph_addr(SCRATCH), '0, '0, scratch_model, 1'b0);
    wait_idle();
    repeat (5) @(negedge clk);

    if (issued_cnt == NUM_REQ && returned_cnt == issued_cnt && exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Request, credit or response count wrong: %0d sent, %0d credits back",
               issued_cnt, returned_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "end of run check failed");
    end
  end

endmodule

// File: project.f
+incdir+include
logic/host_domain_pkg.sv
logic/host_xbar.sv
logic/l2_banks.sv
logic/periph_regs.sv
logic/host_domain.sv
testbench/tb_host_domain.sv

// File: run.sh
#!/usr/bin/env bash
# Build the host domain testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f project.f \
  --top-module tb_host_domain --Mdir obj_dir -o tb_host_domain > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_host_domain > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
